//--- source/dac_spi_pkg.sv
package dac_spi_pkg;

	//////////////////////////////
	// frame geometry
	//////////////////////////////

	// whole dac word, msb goes out first
	localparam int frame_width = 32;

	// field widths, msb to lsb
	localparam int pad_hi_width = 4;
	localparam int cmd_width = 4;
	localparam int addr_width = 4;
	localparam int value_width = 16;
	localparam int pad_lo_width = 4;

	typedef logic [frame_width-1:0] dac_word_t;
	typedef logic [cmd_width-1:0] dac_cmd_t;
	typedef logic [addr_width-1:0] dac_addr_t;
	typedef logic [value_width-1:0] dac_value_t;

	//////////////////////////////
	// command codes
	//////////////////////////////

	// write input register, then update the output
	localparam dac_cmd_t cmd_write_update = 4'd3;

	// zero pad, cmd, addr, value, zero pad
	function automatic dac_word_t pack_frame(dac_cmd_t cmd, dac_addr_t addr, dac_value_t value);
		return {{pad_hi_width{1'b0}}, cmd, addr, value, {pad_lo_width{1'b0}}};
	endfunction

endpackage

//--- source/spi_clk_gen.sv
module spi_clk_gen #(
	// half period of the serial clock, in system cycles
	parameter int SCK_DIV = 2
) (
	input logic CLK50MHZ,
	input logic RST,
	output logic spi_sck_50,
	output logic spi_sck_trig_delay,
	output logic spi_sck_trig_div2_delay
);

	// counter needs at least one bit even for SCK_DIV of 1
	localparam int CNT_W = (SCK_DIV > 1) ? $clog2(SCK_DIV) : 1;
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(SCK_DIV - 1);

	logic [CNT_W-1:0] div_cnt;
	logic sck_src;
	logic sck_src_q;

	//////////////////////////////
	// divider
	//////////////////////////////

	// free running from reset
	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			div_cnt <= '0;
			sck_src <= 1'b0;
		end else if (div_cnt == CNT_LAST) begin
			// half period elapsed, flip the source
			div_cnt <= '0;
			sck_src <= ~sck_src;
		end else begin
			div_cnt <= div_cnt + CNT_W'(1);
		end
	end

	//////////////////////////////
	// edge strobes
	//////////////////////////////

	// previous value of the source for edge detection
	always_ff @(posedge CLK50MHZ) begin
		if (RST)
			sck_src_q <= 1'b0;
		else
			sck_src_q <= sck_src;
	end

	assign spi_sck_50 = sck_src;

	// high in the first cycle after any change
	assign spi_sck_trig_delay = sck_src ^ sck_src_q;

	// high in the first cycle after the fall only
	assign spi_sck_trig_div2_delay = sck_src_q & ~sck_src;

endmodule

//--- source/spi.sv
module spi #(
	parameter int WIDTH = dac_spi_pkg::frame_width,
	// 1: sck only toggles around a frame, 0: sck runs all the time
	parameter int TURNING_OFF_CLK = 0,
	// 1: sck is CLK50MHZ itself, 0: slow source with div2 strobe
	parameter int FASTDAC = 0,
	// 1: clock gate held by a flag and dropped on the next sck edge strobe
	// only meaningful with FASTDAC=0 and TURNING_OFF_CLK=1
	parameter int EARLY_CS_POSEDGE = 0
) (
	input logic RST,
	input logic CLK50MHZ,
	input logic spi_sck_50,
	input logic spi_sck_trig_delay,
	input logic spi_sck_trig_div2_delay,
	output logic spi_sck,
	output logic spi_cs,
	input logic spi_miso,
	output logic spi_mosi,
	input dac_spi_pkg::dac_word_t data_in,
	output dac_spi_pkg::dac_word_t data_out,
	input logic spi_trig,
	output logic spi_done
);

	localparam int IDX_W = $clog2(WIDTH + 1);
	localparam logic [IDX_W-1:0] IDX_FULL = IDX_W'(WIDTH);

	typedef enum logic [1:0] {
		trig_waiting,
		sending,
		done
	} state_t;

	state_t state;
	logic shift_en;
	logic edge_en;
	logic [WIDTH-1:0] shiftreg;
	logic [IDX_W-1:0] shiftreg_idx;
	logic spi_clocking;
	logic spi_sck_en;
	logic sck_src;

	// fast mode shifts every system cycle
	assign shift_en = (FASTDAC != 0) ? 1'b1 : spi_sck_trig_div2_delay;
	assign edge_en = (EARLY_CS_POSEDGE != 0) ? spi_sck_trig_delay : 1'b0;

	//////////////////////////////
	// fsm
	//////////////////////////////

	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			state <= trig_waiting;
		end else begin
			case (state)
				trig_waiting:
					if (spi_trig)
						state <= sending;
				sending:
					// strobe after the last bit closes the frame
					if (shift_en && shiftreg_idx == IDX_FULL)
						state <= done;
				default:
					state <= trig_waiting;
			endcase
		end
	end

	assign spi_done = (state == done);

	//////////////////////////////
	// shifter
	//////////////////////////////

	// word loads while idle, miso enters at the lsb
	always_ff @(posedge CLK50MHZ) begin
		if (state == trig_waiting)
			shiftreg <= data_in;
		else if (state == sending && shift_en && shiftreg_idx < IDX_FULL)
			shiftreg <= {shiftreg[WIDTH-2:0], spi_miso};
	end

	assign data_out = shiftreg;

	// bits sent so far
	always_ff @(posedge CLK50MHZ) begin
		if (RST)
			shiftreg_idx <= '0;
		else if (state == trig_waiting)
			shiftreg_idx <= '0;
		else if (state == sending && shift_en && shiftreg_idx < IDX_FULL)
			shiftreg_idx <= shiftreg_idx + IDX_W'(1);
	end

	// msb first, changes on each strobe
	always_ff @(posedge CLK50MHZ) begin
		if (RST)
			spi_mosi <= 1'b0;
		else if (state == trig_waiting)
			spi_mosi <= 1'b0;
		else if (state == sending && shift_en)
			spi_mosi <= shiftreg[WIDTH-1];
	end

	// low for WIDTH strobes, up again on the closing one
	always_ff @(posedge CLK50MHZ) begin
		if (RST)
			spi_cs <= 1'b1;
		else if (state == trig_waiting)
			spi_cs <= 1'b1;
		else if (state == sending && shift_en)
			spi_cs <= (shiftreg_idx < IDX_FULL) ? 1'b0 : 1'b1;
	end

	//////////////////////////////
	// serial clock gate
	//////////////////////////////

	// set by cs, cleared on an sck edge strobe once cs is up
	always_ff @(posedge CLK50MHZ) begin
		if (RST)
			spi_clocking <= 1'b0;
		else if (!spi_cs)
			spi_clocking <= 1'b1;
		else if (edge_en)
			spi_clocking <= 1'b0;
	end

	always_comb begin
		if (TURNING_OFF_CLK == 0)
			spi_sck_en = 1'b1;
		else if (EARLY_CS_POSEDGE != 0)
			spi_sck_en = spi_clocking;
		else
			spi_sck_en = ~spi_cs;
	end

	assign sck_src = (FASTDAC != 0) ? CLK50MHZ : spi_sck_50;
	assign spi_sck = spi_sck_en ? sck_src : 1'b0;

endmodule

//--- source/dac_frame_builder.sv
module dac_frame_builder #(
	parameter int WIDTH = dac_spi_pkg::frame_width
) (
	input logic CLK50MHZ,
	input logic RST,
	input logic start,
	input dac_spi_pkg::dac_cmd_t cmd,
	input dac_spi_pkg::dac_addr_t addr,
	input dac_spi_pkg::dac_value_t value,
	input logic spi_done,
	input dac_spi_pkg::dac_word_t rx_word,
	output dac_spi_pkg::dac_word_t tx_word,
	output logic spi_trig,
	output logic busy,
	output dac_spi_pkg::dac_word_t rd_data,
	output logic rd_valid
);

	typedef enum logic {
		idle,
		active
	} fb_state_t;

	fb_state_t state;
	logic accept;

	// new command only while the master is free
	assign accept = start && (state == idle);

	//////////////////////////////
	// command acceptance
	//////////////////////////////

	always_ff @(posedge CLK50MHZ) begin
		if (RST)
			state <= idle;
		else if (accept)
			state <= active;
		else if (state == active && spi_done)
			state <= idle;
	end

	// falls together with rd_valid
	assign busy = (state == active);

	// frame held for the master to load while it waits
	always_ff @(posedge CLK50MHZ) begin
		if (accept)
			tx_word <= WIDTH'(dac_spi_pkg::pack_frame(cmd, addr, value));
	end

	// one trigger per accepted command
	always_ff @(posedge CLK50MHZ) begin
		if (RST)
			spi_trig <= 1'b0;
		else
			spi_trig <= accept;
	end

	//////////////////////////////
	// readback
	//////////////////////////////

	// word the dac returned during the frame
	always_ff @(posedge CLK50MHZ) begin
		if (RST)
			rd_data <= '0;
		else if (state == active && spi_done)
			rd_data <= rx_word;
	end

	always_ff @(posedge CLK50MHZ) begin
		if (RST)
			rd_valid <= 1'b0;
		else
			rd_valid <= (state == active) && spi_done;
	end

endmodule

//--- source/dac_spi_top.sv
module dac_spi_top #(
	parameter int SCK_DIV = 2,
	parameter int WIDTH = dac_spi_pkg::frame_width
) (
	input logic CLK50MHZ,
	input logic RST,
	input logic start,
	input dac_spi_pkg::dac_cmd_t cmd,
	input dac_spi_pkg::dac_addr_t addr,
	input dac_spi_pkg::dac_value_t value,
	output logic busy,
	output dac_spi_pkg::dac_word_t rd_data,
	output logic rd_valid,
	output logic spi_sck,
	output logic spi_cs,
	output logic spi_mosi,
	input logic spi_miso
);

	//////////////////////////////
	// internal links
	//////////////////////////////

	logic spi_sck_50;
	logic spi_sck_trig_delay;
	logic spi_sck_trig_div2_delay;
	dac_spi_pkg::dac_word_t tx_word;
	dac_spi_pkg::dac_word_t rx_word;
	logic spi_trig;
	logic spi_done;

	// slow serial clock and its strobes
	spi_clk_gen #(
		.SCK_DIV(SCK_DIV)
	) u_clk_gen (
		.CLK50MHZ(CLK50MHZ),
		.RST(RST),
		.spi_sck_50(spi_sck_50),
		.spi_sck_trig_delay(spi_sck_trig_delay),
		.spi_sck_trig_div2_delay(spi_sck_trig_div2_delay)
	);

	dac_frame_builder #(
		.WIDTH(WIDTH)
	) u_frame_builder (
		.CLK50MHZ(CLK50MHZ),
		.RST(RST),
		.start(start),
		.cmd(cmd),
		.addr(addr),
		.value(value),
		.spi_done(spi_done),
		.rx_word(rx_word),
		.tx_word(tx_word),
		.spi_trig(spi_trig),
		.busy(busy),
		.rd_data(rd_data),
		.rd_valid(rd_valid)
	);

	// slow clock, sck gated by cs
	spi #(
		.WIDTH(WIDTH),
		.TURNING_OFF_CLK(1),
		.FASTDAC(0),
		.EARLY_CS_POSEDGE(0)
	) u_spi (
		.RST(RST),
		.CLK50MHZ(CLK50MHZ),
		.spi_sck_50(spi_sck_50),
		.spi_sck_trig_delay(spi_sck_trig_delay),
		.spi_sck_trig_div2_delay(spi_sck_trig_div2_delay),
		.spi_sck(spi_sck),
		.spi_cs(spi_cs),
		.spi_miso(spi_miso),
		.spi_mosi(spi_mosi),
		.data_in(tx_word),
		.data_out(rx_word),
		.spi_trig(spi_trig),
		.spi_done(spi_done)
	);

endmodule

//--- testbench/dac_spi_chk.sv
module dac_spi_chk #(
	parameter int WIDTH = 32
) (
	input logic CLK50MHZ,
	input logic RST,
	input logic spi_sck,
	input logic spi_cs,
	input logic spi_done,
	input logic shift_strobe
);
	timeunit 1ns;
	timeprecision 1ps;

	// strobes seen while cs is low, the closing one included
	int low_strobes = 0;

	always @(posedge CLK50MHZ) begin
		if (RST || spi_cs)
			low_strobes <= 0;
		else if (shift_strobe)
			low_strobes <= low_strobes + 1;
	end

	//////////////////////////////
	// protocol rules
	//////////////////////////////

	// gated clock
	sck_gated: assert property (@(posedge CLK50MHZ) disable iff (RST) spi_cs |-> !spi_sck)
		else $error("spi_sck high while spi_cs is high");

	done_pulse: assert property (@(posedge CLK50MHZ) disable iff (RST) spi_done |=> !spi_done)
		else $error("spi_done longer than one cycle");

	// frame length in strobes
	cs_strobes: assert property (@(posedge CLK50MHZ) disable iff (RST)
		$rose(spi_cs) |-> low_strobes == WIDTH)
		else $error("spi_cs low for %0d strobes", low_strobes);

endmodule

bind spi dac_spi_chk #(
	.WIDTH(WIDTH)
) u_chk (
	.CLK50MHZ(CLK50MHZ),
	.RST(RST),
	.spi_sck(spi_sck),
	.spi_cs(spi_cs),
	.spi_done(spi_done),
	.shift_strobe(spi_sck_trig_div2_delay)
);

//--- testbench/dac_spi_tb.sv
module dac_spi_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int SCK_DIV = 2;
	localparam int WIDTH = dac_spi_pkg::frame_width;
	localparam int ROWS = 8;
	localparam int RESET_CYCLES = 8;
	// worst frame plus slack per row, then reset
	localparam int CYCLE_LIMIT = ROWS * (34 * 2 * SCK_DIV + 20) + RESET_CYCLES;

	logic CLK50MHZ = 1'b0;
	logic RST;
	logic start;
	dac_spi_pkg::dac_cmd_t cmd;
	dac_spi_pkg::dac_addr_t addr;
	dac_spi_pkg::dac_value_t value;
	logic busy;
	dac_spi_pkg::dac_word_t rd_data;
	logic rd_valid;
	logic spi_sck;
	logic spi_cs;
	logic spi_mosi;
	logic spi_miso;

	// command table, one row per frame
	dac_spi_pkg::dac_cmd_t tbl_cmd [ROWS];
	dac_spi_pkg::dac_addr_t tbl_addr [ROWS];
	dac_spi_pkg::dac_value_t tbl_value [ROWS];
	dac_spi_pkg::dac_word_t tbl_readback [ROWS];
	logic tbl_busy_start [ROWS];

	// slave model state
	dac_spi_pkg::dac_word_t slave_rb = '0;
	dac_spi_pkg::dac_word_t slave_rx = '0;
	logic [5:0] slave_bit = '0;
	logic [5:0] frame_bits = '0;
	int frame_count = 0;

	int checks = 0;
	int test_errors = 0;
	int mon_errors = 0;
	int cycle_count;
	logic busy_q = 1'b0;

	dac_spi_top #(
		.SCK_DIV(SCK_DIV),
		.WIDTH(WIDTH)
	) uut (
		.CLK50MHZ(CLK50MHZ),
		.RST(RST),
		.start(start),
		.cmd(cmd),
		.addr(addr),
		.value(value),
		.busy(busy),
		.rd_data(rd_data),
		.rd_valid(rd_valid),
		.spi_sck(spi_sck),
		.spi_cs(spi_cs),
		.spi_mosi(spi_mosi),
		.spi_miso(spi_miso)
	);

	// 50 MHz
	initial begin
		forever #10 CLK50MHZ = ~CLK50MHZ;
	end

	//////////////////////////////
	// dac slave model
	//////////////////////////////

	// current readback bit, msb waits on the line before cs falls
	assign spi_miso = (slave_bit < 6'd32) ? slave_rb[5'd31 - slave_bit[4:0]] : 1'b0;

	// mosi in on rising sck, bit count kept per frame
	always @(posedge spi_sck or posedge spi_cs) begin
		if (spi_cs) begin
			frame_bits <= slave_bit;
			slave_bit <= '0;
		end else begin
			slave_rx <= {slave_rx[30:0], spi_mosi};
			slave_bit <= slave_bit + 6'd1;
		end
	end

	// one count per cs low period
	always @(negedge spi_cs) begin
		if (!RST)
			frame_count <= frame_count + 1;
	end

	//////////////////////////////
	// idle line monitor
	//////////////////////////////

	always @(negedge CLK50MHZ) begin
		if (!RST) begin
			// no frame while idle
			if (!busy) begin
				assert (spi_cs === 1'b1) else begin
					$display("** Error at %0d ns: spi_cs = %b, expected 1", $time, spi_cs);
					mon_errors++;
				end
				assert (spi_sck === 1'b0) else begin
					$display("** Error at %0d ns: spi_sck = %b, expected 0", $time, spi_sck);
					mon_errors++;
				end
			end
			assert (!(busy_q && !busy) || rd_valid) else begin
				$display("busy fell at %0d ns without an rd_valid pulse", $time);
				mon_errors++;
			end
		end
		busy_q <= busy;
	end

	//////////////////////////////
	// helpers
	//////////////////////////////

	// layout: pad, cmd 27..24, addr 23..20, value 19..4, pad
	function automatic dac_spi_pkg::dac_word_t frame_from_fields(
		input dac_spi_pkg::dac_cmd_t c,
		input dac_spi_pkg::dac_addr_t a,
		input dac_spi_pkg::dac_value_t v
	);
		dac_spi_pkg::dac_word_t w;
		w = '0;
		w[27:24] = c;
		w[23:20] = a;
		w[19:4] = v;
		return w;
	endfunction

	task automatic check_word(input string name, input dac_spi_pkg::dac_word_t got,
		input dac_spi_pkg::dac_word_t exp);
		checks++;
		assert (got === exp) else begin
			$display("** Error at %0d ns: %s = %h, expected %h", $time, name, got, exp);
			test_errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		assert (got === exp) else begin
			$display("** Error at %0d ns: %s = %b, expected %b", $time, name, got, exp);
			test_errors++;
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		checks++;
		assert (got == exp) else begin
			$display("** Error at %0d ns: %s = %0d, expected %0d", $time, name, got, exp);
			test_errors++;
		end
	endtask

	// fixed corner rows first, random rows after
	task automatic fill_table();
		tbl_cmd[0] = dac_spi_pkg::cmd_write_update;
		tbl_addr[0] = 4'h0;
		tbl_value[0] = 16'h0000;
		tbl_readback[0] = 32'hA5C3_0F96;
		tbl_cmd[1] = dac_spi_pkg::cmd_write_update;
		tbl_addr[1] = 4'hF;
		tbl_value[1] = 16'hFFFF;
		tbl_readback[1] = 32'hFFFF_FFFF;
		tbl_cmd[2] = 4'h1;
		tbl_addr[2] = 4'h5;
		tbl_value[2] = 16'h8001;
		tbl_readback[2] = 32'h8000_0001;
		tbl_cmd[3] = 4'hF;
		tbl_addr[3] = 4'hA;
		tbl_value[3] = 16'h5A5A;
		tbl_readback[3] = 32'h0000_0000;
		for (int r = 0; r < ROWS; r++) begin
			tbl_busy_start[r] = (r == 2 || r == 5);
			if (r >= 4) begin
				tbl_cmd[r] = dac_spi_pkg::dac_cmd_t'($urandom());
				tbl_addr[r] = dac_spi_pkg::dac_addr_t'($urandom());
				tbl_value[r] = dac_spi_pkg::dac_value_t'($urandom());
				tbl_readback[r] = $urandom();
			end
		end
	endtask

	// one command, optional ignored start, then checks at rd_valid
	task automatic run_row(input int row);
		dac_spi_pkg::dac_word_t exp_frame;
		int frames_before;
		int errors_before;
		exp_frame = frame_from_fields(tbl_cmd[row], tbl_addr[row], tbl_value[row]);
		frames_before = frame_count;
		errors_before = test_errors;
		@(negedge CLK50MHZ);
		slave_rb = tbl_readback[row];
		cmd = tbl_cmd[row];
		addr = tbl_addr[row];
		value = tbl_value[row];
		start = 1'b1;
		@(negedge CLK50MHZ);
		start = 0;
		check_bit("busy", busy, 1'b1);
		if (tbl_busy_start[row]) begin
			// second command held through the whole busy period, must not reach the wire
			cmd = ~tbl_cmd[row];
			addr = ~tbl_addr[row];
			value = ~tbl_value[row];
			start = 1'b1;
		end
		while (rd_valid !== 1'b1)
			@(negedge CLK50MHZ);
		start = 1'b0;
		check_word("rd_data", rd_data, tbl_readback[row]);
		check_word("slave_rx", slave_rx, exp_frame);
		check_count("frame_bits", int'(frame_bits), WIDTH);
		check_count("frame_count", frame_count - frames_before, 1);
		if (test_errors == errors_before)
			$display("row %0d cmd %h addr %h value %h: ok", row, tbl_cmd[row], tbl_addr[row],
				tbl_value[row]);
		else
			$display("row %0d cmd %h addr %h value %h: mismatch", row, tbl_cmd[row],
				tbl_addr[row], tbl_value[row]);
	endtask

	//////////////////////////////
	// main sequence
	//////////////////////////////

	initial begin
		int errors_before;
		RST = 1'b1;
		start = 1'b0;
		cmd = '0;
		addr = '0;
		value = '0;
		void'($urandom(81630));
		fill_table();
		repeat (RESET_CYCLES) @(negedge CLK50MHZ);
		RST = 1'b0;
		@(negedge CLK50MHZ);

		// idle outputs right after reset
		errors_before = test_errors;
		check_bit("spi_cs", spi_cs, 1'b1);
		check_bit("spi_sck", spi_sck, 1'b0);
		check_bit("spi_mosi", spi_mosi, 1'b0);
		check_bit("busy", busy, 1'b0);
		check_bit("rd_valid", rd_valid, 1'b0);
		check_word("rd_data", rd_data, '0);
		if (test_errors == errors_before)
			$display("reset values: ok");
		else
			$display("reset values: mismatch");

		for (int r = 0; r < ROWS; r++)
			run_row(r);

		// ignored starts leave no frame behind
		check_count("frame_count", frame_count, ROWS);
		$display("rows: %0d, checks: %0d, errors: %0d", ROWS, checks, test_errors + mon_errors);
		if (test_errors + mon_errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

	// run limit
	initial begin
		cycle_count = 0;
		while (cycle_count < CYCLE_LIMIT) begin
			@(posedge CLK50MHZ);
			cycle_count++;
		end
		$display("timeout after %0d cycles, the command sequence did not finish", cycle_count);
		$display("Test failed");
		$finish;
	end

endmodule

//--- verilog.f
source/dac_spi_pkg.sv
source/spi_clk_gen.sv
source/spi.sv
source/dac_frame_builder.sv
source/dac_spi_top.sv
testbench/dac_spi_chk.sv
testbench/dac_spi_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the DAC SPI testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module dac_spi_tb -f verilog.f -o Vdac_spi_tb

# a crash or stop still leaves the log for the search below
./obj_dir/Vdac_spi_tb > sim.log 2>&1 || true
cat sim.log

# fails the script when the pass line is missing
grep -qx "Test passed" sim.log
echo "simulation log check ok"
